// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = nn_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/nn_model.svh ====
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// ------------------------------
// model state
// ------------------------------
nn_pkg::fx_t m_w1 [nn_pkg::W1_NUM];  // m_w1[4i+j] feeds hidden i
nn_pkg::fx_t m_w2 [nn_pkg::W2_NUM];
nn_pkg::fx_t m_h  [nn_pkg::HID_DIM]; // sums of the last forward pass
nn_pkg::fx_t m_y  [nn_pkg::HID_DIM]; // relu of those sums
int          m_sample;               // index inside epoch
int          m_epoch;                // index inside run

// Q8.8 product keeps the middle 16 of the 32 product bits
function automatic nn_pkg::fx_t q_mul(input nn_pkg::fx_t a, input nn_pkg::fx_t b);
	logic signed [31:0] full;
	full = a * b;
	return full[nn_pkg::FRAC_W +: nn_pkg::DATA_W];
endfunction

function automatic void clear_model();
	foreach (m_w1[i])
		m_w1[i] = '0;
	foreach (m_w2[i])
		m_w2[i] = '0;
	m_sample = 0;
	m_epoch  = 0;
endfunction

// rate halves once per EPOCHS_PER_LR epochs up to LR_RATES-1 times
function automatic int scheduled_lr_shift();
	int step;
	step = m_epoch / EPOCHS_PER_LR;
	if (step > nn_pkg::LR_RATES - 1)
		step = nn_pkg::LR_RATES - 1;
	return LR_BASE_SHIFT + step;
endfunction

function automatic nn_pkg::fx_t forward_pass(input nn_pkg::fx_t s [nn_pkg::IN_DIM]);
	nn_pkg::fx_t acc;
	acc = '0;
	for (int i = 0; i < nn_pkg::HID_DIM; i++) begin
		m_h[i] = '0;
		for (int j = 0; j < nn_pkg::IN_DIM; j++)
			m_h[i] = m_h[i] + q_mul(s[j], m_w1[nn_pkg::IN_DIM * i + j]); // wraps
		m_y[i] = (m_h[i] > 0) ? m_h[i] : '0;
		acc    = acc + q_mul(m_y[i], m_w2[i]);
	end
	return acc;
endfunction

// sgd step on the old weights before the counters move
function automatic void sgd_step(input nn_pkg::fx_t s [nn_pkg::IN_DIM],
	input nn_pkg::fx_t tgt, input nn_pkg::fx_t y_pred);
	nn_pkg::fx_t d2;
	nn_pkg::fx_t d2_lr;
	nn_pkg::fx_t d1;
	nn_pkg::fx_t w2_old [nn_pkg::W2_NUM];
	int          sh;
	sh     = scheduled_lr_shift();
	d2     = y_pred - tgt;
	d2_lr  = d2 >>> sh;
	w2_old = m_w2;
	for (int i = 0; i < nn_pkg::HID_DIM; i++) begin
		d1      = (m_h[i] > 0) ? q_mul(d2, w2_old[i]) : '0; // dead neuron blocks
		m_w2[i] = m_w2[i] - q_mul(d2_lr, m_y[i]);
		for (int j = 0; j < nn_pkg::IN_DIM; j++)
			m_w1[nn_pkg::IN_DIM * i + j] = m_w1[nn_pkg::IN_DIM * i + j]
				- q_mul(d1, s[j] >>> sh);
	end
	if (m_sample == DATASET_SIZE - 1) begin
		m_sample = 0;
		m_epoch  = (m_epoch == EPOCH_COUNT - 1) ? 0 : m_epoch + 1; // run ends
	end else begin
		m_sample = m_sample + 1;
	end
endfunction

`endif

// ==== dv/nn_tb.sv ====
`timescale 1ns/100ps

module nn_tb;

	localparam int DATASET_SIZE  = 3;
	localparam int EPOCH_COUNT   = 5;
	localparam int EPOCHS_PER_LR = 1;
	localparam int LR_BASE_SHIFT = 3;
	localparam int N_SAMPLES     = DATASET_SIZE * (EPOCH_COUNT + 1) + 6; // zero-weight + run + extras
	localparam int N_LOADS       = 2;
	localparam int CYCLE_LIMIT   = 10 + N_SAMPLES * 10 + N_LOADS * 16 + 20;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        in_valid_d;
	logic        in_valid_t;
	logic        in_valid_w1;
	logic        in_valid_w2;
	nn_pkg::fx_t data_point;
	nn_pkg::fx_t target;
	nn_pkg::fx_t weight1;
	nn_pkg::fx_t weight2;
	logic        out_valid;
	nn_pkg::fx_t out;

	logic [31:0] lfsr = 32'h6883_08de;
	int          cycles       = 0;
	int          pulses       = 0; // cycles with out_valid high
	int          samples_sent = 0;

	`include "nn_model.svh"

	nn_top #(
		.DATASET_SIZE  (DATASET_SIZE),
		.EPOCH_COUNT   (EPOCH_COUNT),
		.EPOCHS_PER_LR (EPOCHS_PER_LR),
		.LR_BASE_SHIFT (LR_BASE_SHIFT)
	) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_d  (in_valid_d),
		.in_valid_t  (in_valid_t),
		.in_valid_w1 (in_valid_w1),
		.in_valid_w2 (in_valid_w2),
		.data_point  (data_point),
		.target      (target),
		.weight1     (weight1),
		.weight2     (weight2),
		.out_valid   (out_valid),
		.out         (out)
	);

	always #50 clk = ~clk; // 100 ns period

	// ------------------------------
	// failure reporting
	// ------------------------------
	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("** Error at %0t: %s expected %0d got %0d", $time, what, expected, actual);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_check(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// galois lfsr stepped once per bit
	function automatic logic next_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hD000_0001;
		return b;
	endfunction

	function automatic nn_pkg::fx_t rand_fx();
		logic [9:0] r;
		r = '0;
		for (int i = 0; i < 10; i++)
			r = {r[8:0], next_bit()};
		return {{6{r[9]}}, r}; // about +-2.0 in Q8.8
	endfunction

	// ------------------------------
	// stimulus tasks
	// ------------------------------
	task automatic load_weights();
		nn_pkg::fx_t v;
		for (int i = 0; i < nn_pkg::W1_NUM; i++) begin
			v       = rand_fx();
			m_w1[i] = v;
			@(posedge clk);
			in_valid_w1 <= 1'b1;
			weight1     <= v; // index order 0..11
		end
		for (int i = 0; i < nn_pkg::W2_NUM; i++) begin
			v       = rand_fx();
			m_w2[i] = v;
			@(posedge clk);
			in_valid_w1 <= 1'b0;
			weight1     <= '0;
			in_valid_w2 <= 1'b1;
			weight2     <= v;
		end
		@(posedge clk);
		in_valid_w2 <= 1'b0;
		weight2     <= '0;
		m_sample = 0; // load restarts the schedule
		m_epoch  = 0;
	endtask

	task automatic run_sample();
		nn_pkg::fx_t sv [nn_pkg::IN_DIM];
		nn_pkg::fx_t tgt;
		nn_pkg::fx_t exp_out;
		int          edges;
		for (int j = 0; j < nn_pkg::IN_DIM; j++)
			sv[j] = rand_fx();
		tgt     = rand_fx();
		exp_out = forward_pass(sv);
		for (int j = 0; j < nn_pkg::IN_DIM; j++) begin
			@(posedge clk);
			in_valid_d <= 1'b1;
			in_valid_t <= (j == 0); // target rides on s0
			data_point <= sv[j];
			target     <= (j == 0) ? tgt : '0;
		end
		@(posedge clk); // edge k takes s3
		in_valid_d <= 1'b0;
		in_valid_t <= 1'b0;
		data_point <= '0;
		target     <= '0;
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
			@(negedge clk); // outputs settled
		end while (!out_valid && edges < 6);
		assert (edges == 2) else report_mismatch("out_valid delay in edges", 2, edges);
		assert (out == exp_out) else report_mismatch("out", exp_out, out);
		@(negedge clk);
		assert (!out_valid) else fail_check("out_valid stayed high for more than one cycle");
		sgd_step(sv, tgt, exp_out);
		samples_sent++;
	endtask

	// ------------------------------
	// monitors
	// ------------------------------
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (out_valid)
				pulses++;
			else
				assert (out == '0) else report_mismatch("out while out_valid low", 0, out);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		rst_n       <= 1'b0;
		in_valid_d  <= 1'b0;
		in_valid_t  <= 1'b0;
		in_valid_w1 <= 1'b0;
		in_valid_w2 <= 1'b0;
		data_point  <= '0;
		target      <= '0;
		weight1     <= '0;
		weight2     <= '0;
		clear_model();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!out_valid) else fail_check("out_valid high after reset");
		assert (out == '0) else report_mismatch("out after reset", 0, out);
		run_sample(); // weights still zero from reset
		load_weights();
		for (int n = 0; n < DATASET_SIZE * (EPOCH_COUNT + 1) + 2; n++)
			run_sample(); // full run and one more epoch plus two
		load_weights(); // reload in epoch 1 with one sample left
		run_sample();
		run_sample();
		run_sample();
		assert (pulses == samples_sent)
			else report_mismatch("out_valid pulse count", samples_sent, pulses);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+dv
src/nn_pkg.sv
src/weight_if.sv
src/train_ctrl.sv
src/sample_buffer.sv
src/weight_bank.sv
src/forward_path.sv
src/backprop_update.sv
src/nn_top.sv
dv/nn_tb.sv

// ==== src/backprop_update.sv ====
`timescale 1ns/100ps

module backprop_update (
	input  logic                       update_en,
	input  nn_pkg::lr_shift_t          lr_shift,
	input  nn_pkg::fx_t                s [nn_pkg::IN_DIM],
	input  nn_pkg::fx_t                y [nn_pkg::HID_DIM],
	input  logic [nn_pkg::HID_DIM-1:0] h_pos,
	input  nn_pkg::fx_t                delta2,
	weight_if.user                     wif
);

	nn_pkg::fx_t d2_lr;                   // lr * delta2
	nn_pkg::fx_t s_lr   [nn_pkg::IN_DIM]; // lr * s_j
	nn_pkg::fx_t delta1 [nn_pkg::HID_DIM];

	assign d2_lr = delta2 >>> lr_shift; // arithmetic, keeps sign

	// all gradients from the old weights
	always_comb begin
		for (int j = 0; j < nn_pkg::IN_DIM; j++)
			s_lr[j] = s[j] >>> lr_shift;
		for (int i = 0; i < nn_pkg::HID_DIM; i++) begin
			// backprop through ReLU, dead neuron passes nothing
			delta1[i] = h_pos[i] ? nn_pkg::fx_mul(delta2, wif.w2[i]) : '0;
			wif.w2_next[i] = wif.w2[i] - nn_pkg::fx_mul(d2_lr, y[i]);
			for (int j = 0; j < nn_pkg::IN_DIM; j++)
				wif.w1_next[nn_pkg::IN_DIM * i + j] = wif.w1[nn_pkg::IN_DIM * i + j]
					- nn_pkg::fx_mul(delta1[i], s_lr[j]);
		end
	end

	assign wif.upd = update_en; // bank commits on this edge

endmodule

// ==== src/forward_path.sv ====
`timescale 1ns/100ps

module forward_path (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       hidden_en,
	input  logic                       out_en,
	input  nn_pkg::fx_t                s [nn_pkg::IN_DIM],
	input  nn_pkg::fx_t                target_q,
	weight_if.user                     wif,
	output logic [nn_pkg::HID_DIM-1:0] h_pos,
	output nn_pkg::fx_t                y [nn_pkg::HID_DIM],
	output nn_pkg::fx_t                delta2,
	output logic                       out_valid,
	output nn_pkg::fx_t                out
);

	nn_pkg::fx_t h [nn_pkg::HID_DIM]; // pre-activation sums
	nn_pkg::fx_t y_pred;              // output neuron, linear

	// ------------------------------
	// hidden layer MAC
	// ------------------------------
	always_comb begin
		for (int i = 0; i < nn_pkg::HID_DIM; i++) begin
			h[i] = '0;
			for (int j = 0; j < nn_pkg::IN_DIM; j++)
				h[i] = h[i] + nn_pkg::fx_mul(s[j], wif.w1[nn_pkg::IN_DIM * i + j]);
		end
	end

	always_ff @(posedge clk) begin
		if (hidden_en) begin
			for (int i = 0; i < nn_pkg::HID_DIM; i++) begin
				h_pos[i] <= (h[i] > 0);        // gates delta1 later
				y[i]     <= (h[i] > 0) ? h[i] : '0; // ReLU
			end
		end
	end

	// ------------------------------
	// output neuron
	// ------------------------------
	always_comb begin
		y_pred = '0;
		for (int i = 0; i < nn_pkg::HID_DIM; i++)
			y_pred = y_pred + nn_pkg::fx_mul(y[i], wif.w2[i]);
	end

	always_ff @(posedge clk) begin
		if (out_en)
			delta2 <= y_pred - target_q; // error, wraps
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out       <= '0;
		end else begin
			out_valid <= out_en;               // single pulse per sample
			out       <= out_en ? y_pred : '0; // zero while not valid
		end
	end

endmodule

// ==== src/nn_pkg.sv ====
package nn_pkg;

	// ------------------------------
	// fixed point format
	// ------------------------------
	localparam int DATA_W = 16; // every value on the datapath
	localparam int FRAC_W = 8;  // Q8.8

	typedef logic signed [DATA_W-1:0] fx_t; // weights, data, activations, out
	typedef logic [3:0] lr_shift_t;         // learning rate as 2^-lr_shift

	// ------------------------------
	// network shape
	// ------------------------------
	localparam int IN_DIM  = 4;
	localparam int HID_DIM = 3;
	localparam int W1_NUM  = IN_DIM * HID_DIM; // index 4i+j feeds hidden i
	localparam int W2_NUM  = HID_DIM;          // one per hidden neuron

	// training defaults, overridden from the top
	localparam int DEF_DATASET_SIZE  = 100; // samples per epoch
	localparam int DEF_EPOCH_COUNT   = 25;  // epochs per run
	localparam int DEF_EPOCHS_PER_LR = 4;   // epochs between halvings
	localparam int DEF_LR_BASE_SHIFT = 6;   // first rate 1/64
	localparam int LR_RATES          = 7;   // rate stops halving after this

	typedef enum logic [2:0] {
		IDLE,    // weight load or first data word
		COLLECT, // words 1 to 3
		HIDDEN,  // hidden MAC and ReLU
		OUTPUT,  // y_pred and error
		UPDATE   // weight write-back
	} train_state_e;

	// Q8.8 product, rescaled then wrapped to 16 bits
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		logic signed [2*DATA_W-1:0] p;
		p = a * b;
		return fx_t'(p >>> FRAC_W);
	endfunction

endpackage

// ==== src/nn_top.sv ====
`timescale 1ns/100ps

module nn_top #(
	parameter int DATASET_SIZE  = nn_pkg::DEF_DATASET_SIZE,
	parameter int EPOCH_COUNT   = nn_pkg::DEF_EPOCH_COUNT,
	parameter int EPOCHS_PER_LR = nn_pkg::DEF_EPOCHS_PER_LR,
	parameter int LR_BASE_SHIFT = nn_pkg::DEF_LR_BASE_SHIFT
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid_d,
	input  logic        in_valid_t,
	input  logic        in_valid_w1,
	input  logic        in_valid_w2,
	input  nn_pkg::fx_t data_point,
	input  nn_pkg::fx_t target,
	input  nn_pkg::fx_t weight1,
	input  nn_pkg::fx_t weight2,
	output logic        out_valid,
	output nn_pkg::fx_t out
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic                       hidden_en; // step k to k+1
	logic                       out_en;    // step k+1 to k+2
	logic                       update_en; // step k+2 to k+3
	nn_pkg::lr_shift_t          lr_shift;
	nn_pkg::fx_t                s [nn_pkg::IN_DIM];
	nn_pkg::fx_t                target_q;
	logic [nn_pkg::HID_DIM-1:0] h_pos;
	nn_pkg::fx_t                y [nn_pkg::HID_DIM];
	nn_pkg::fx_t                delta2;

	weight_if wif ();

	train_ctrl #(
		.DATASET_SIZE  (DATASET_SIZE),
		.EPOCH_COUNT   (EPOCH_COUNT),
		.EPOCHS_PER_LR (EPOCHS_PER_LR),
		.LR_BASE_SHIFT (LR_BASE_SHIFT)
	) u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_d  (in_valid_d),
		.in_valid_w1 (in_valid_w1),
		.in_valid_w2 (in_valid_w2),
		.hidden_en   (hidden_en),
		.out_en      (out_en),
		.update_en   (update_en),
		.lr_shift    (lr_shift)
	);

	sample_buffer u_buf (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_d (in_valid_d),
		.in_valid_t (in_valid_t),
		.data_point (data_point),
		.target     (target),
		.s          (s),
		.target_q   (target_q)
	);

	weight_bank u_bank (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_w1 (in_valid_w1),
		.in_valid_w2 (in_valid_w2),
		.weight1     (weight1),
		.weight2     (weight2),
		.wif         (wif)
	);

	forward_path u_fwd (
		.clk       (clk),
		.rst_n     (rst_n),
		.hidden_en (hidden_en),
		.out_en    (out_en),
		.s         (s),
		.target_q  (target_q),
		.wif       (wif),
		.h_pos     (h_pos),
		.y         (y),
		.delta2    (delta2),
		.out_valid (out_valid),
		.out       (out)
	);

	backprop_update u_bp (
		.update_en (update_en),
		.lr_shift  (lr_shift),
		.s         (s),
		.y         (y),
		.h_pos     (h_pos),
		.delta2    (delta2),
		.wif       (wif)
	);

endmodule

// ==== src/sample_buffer.sv ====
`timescale 1ns/100ps

module sample_buffer (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid_d,
	input  logic        in_valid_t,
	input  nn_pkg::fx_t data_point,
	input  nn_pkg::fx_t target,
	output nn_pkg::fx_t s [nn_pkg::IN_DIM],
	output nn_pkg::fx_t target_q
);

	// four-deep shift so s0 settles in slot 0
	always_ff @(posedge clk) begin
		if (in_valid_d) begin
			for (int i = 0; i < nn_pkg::IN_DIM - 1; i++)
				s[i] <= s[i + 1]; // older words move down
			s[nn_pkg::IN_DIM - 1] <= data_point;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_t)
			target_q <= target; // held until next sample
	end

	// target only rides on a data word
	a_target_first: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid_t |-> in_valid_d);

endmodule

// ==== src/train_ctrl.sv ====
`timescale 1ns/100ps

module train_ctrl #(
	parameter int DATASET_SIZE  = nn_pkg::DEF_DATASET_SIZE,
	parameter int EPOCH_COUNT   = nn_pkg::DEF_EPOCH_COUNT,
	parameter int EPOCHS_PER_LR = nn_pkg::DEF_EPOCHS_PER_LR,
	parameter int LR_BASE_SHIFT = nn_pkg::DEF_LR_BASE_SHIFT
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid_d,
	input  logic              in_valid_w1,
	input  logic              in_valid_w2,
	output logic              hidden_en,
	output logic              out_en,
	output logic              update_en,
	output nn_pkg::lr_shift_t lr_shift
);

	localparam int SAMP_W  = $clog2(DATASET_SIZE + 1);
	localparam int EPOCH_W = $clog2(EPOCH_COUNT + 1);

	nn_pkg::train_state_e state;
	nn_pkg::train_state_e state_nxt;
	logic [1:0]           word_cnt;   // data words seen, wraps after s3
	logic [SAMP_W-1:0]    sample_idx; // position in epoch
	logic [EPOCH_W-1:0]   epoch;      // position in run
	logic [31:0]          lr_step;    // halvings so far, uncapped
	logic                 w_load;     // either weight strobe

	assign w_load = in_valid_w1 | in_valid_w2;

	// ------------------------------
	// FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= nn_pkg::IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state; // hold by default
		case (state)
			nn_pkg::IDLE: begin
				if (in_valid_d)
					state_nxt = nn_pkg::COLLECT; // s0 taken
			end
			nn_pkg::COLLECT: begin
				if (in_valid_d && word_cnt == 2'd3)
					state_nxt = nn_pkg::HIDDEN; // s3 taken, edge k
			end
			nn_pkg::HIDDEN: state_nxt = nn_pkg::OUTPUT;
			nn_pkg::OUTPUT: state_nxt = nn_pkg::UPDATE;
			nn_pkg::UPDATE: state_nxt = nn_pkg::IDLE;
			default:        state_nxt = nn_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			word_cnt <= '0;
		else if (in_valid_d)
			word_cnt <= word_cnt + 2'd1; // back to 0 after four words
	end

	// one-cycle step strobes
	assign hidden_en = (state == nn_pkg::HIDDEN);
	assign out_en    = (state == nn_pkg::OUTPUT);
	assign update_en = (state == nn_pkg::UPDATE);

	// ------------------------------
	// sample and epoch counters
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_idx <= '0;
			epoch      <= '0;
		end else if (w_load) begin
			sample_idx <= '0; // new weights start a fresh run
			epoch      <= '0;
		end else if (update_en) begin
			if (sample_idx == SAMP_W'(DATASET_SIZE - 1)) begin
				sample_idx <= '0;
				if (epoch == EPOCH_W'(EPOCH_COUNT - 1))
					epoch <= '0; // run finished
				else
					epoch <= epoch + 1'b1;
			end else begin
				sample_idx <= sample_idx + 1'b1;
			end
		end
	end

	// lr halves every EPOCHS_PER_LR epochs, capped
	assign lr_step  = 32'(epoch) / 32'(EPOCHS_PER_LR);
	assign lr_shift = (lr_step >= 32'(nn_pkg::LR_RATES - 1))
		? nn_pkg::lr_shift_t'(LR_BASE_SHIFT + nn_pkg::LR_RATES - 1)
		: nn_pkg::lr_shift_t'(32'(LR_BASE_SHIFT) + lr_step);

	// source must leave room for the compute steps
	a_no_data_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(state inside {nn_pkg::HIDDEN, nn_pkg::OUTPUT, nn_pkg::UPDATE}) |-> !in_valid_d);

	// weights only change hands between samples
	a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
		w_load |-> (state == nn_pkg::IDLE));

endmodule

// ==== src/weight_bank.sv ====
`timescale 1ns/100ps

module weight_bank (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid_w1,
	input  logic        in_valid_w2,
	input  nn_pkg::fx_t weight1,
	input  nn_pkg::fx_t weight2,
	weight_if.bank      wif
);

	nn_pkg::fx_t w1_q [nn_pkg::W1_NUM]; // w1_q[4i+j] feeds hidden i
	nn_pkg::fx_t w2_q [nn_pkg::W2_NUM];

	// ------------------------------
	// layer 1
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < nn_pkg::W1_NUM; i++)
				w1_q[i] <= '0;
		end else if (in_valid_w1) begin
			for (int i = 0; i < nn_pkg::W1_NUM - 1; i++)
				w1_q[i] <= w1_q[i + 1]; // serial shift down
			w1_q[nn_pkg::W1_NUM - 1] <= weight1; // newest at top
		end else if (wif.upd) begin
			w1_q <= wif.w1_next; // all 12 at once
		end
	end

	// ------------------------------
	// layer 2
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < nn_pkg::W2_NUM; i++)
				w2_q[i] <= '0;
		end else if (in_valid_w2) begin
			for (int i = 0; i < nn_pkg::W2_NUM - 1; i++)
				w2_q[i] <= w2_q[i + 1];
			w2_q[nn_pkg::W2_NUM - 1] <= weight2;
		end else if (wif.upd) begin
			w2_q <= wif.w2_next;
		end
	end

	assign wif.w1 = w1_q;
	assign wif.w2 = w2_q;

	// write-back and serial load never collide
	a_upd_no_load: assert property (@(posedge clk) disable iff (!rst_n)
		wif.upd |-> !(in_valid_w1 || in_valid_w2));

endmodule

// ==== src/weight_if.sv ====
`timescale 1ns/100ps

interface weight_if;

	nn_pkg::fx_t w1      [nn_pkg::W1_NUM]; // live layer-1 weights
	nn_pkg::fx_t w2      [nn_pkg::W2_NUM]; // live layer-2 weights
	nn_pkg::fx_t w1_next [nn_pkg::W1_NUM]; // sgd result, layer 1
	nn_pkg::fx_t w2_next [nn_pkg::W2_NUM]; // sgd result, layer 2
	logic        upd;                      // one-cycle write-back strobe

	// store side
	modport bank (
		output w1, w2,
		input  w1_next, w2_next, upd
	);

	// arithmetic side
	modport user (
		input  w1, w2,
		output w1_next, w2_next, upd
	);

endinterface
